// ==== logic/bit_serial_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_serial_mac #(
	parameter int N_INPUTS = pim_pkg::N_INPUTS,
	parameter int N_COLS = pim_pkg::N_COLS
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  job_load,
	input  pim_pkg::job_t         job,
	input  pim_pkg::vector_t      vector,
	input  logic                  weight_wr,
	input  pim_pkg::col_addr_t    weight_col,
	input  logic [2*N_INPUTS-1:0] weight_data,
	output logic                  mac_valid,
	output pim_pkg::result_t      result
);
	import pim_pkg::*;

	localparam int NIB_W = ELEM_W / 2;
	localparam int CNT_W = $clog2(N_INPUTS + 1);
	localparam logic [1:0] LAST_BIT = 2'(NIB_W - 1);

	vector_t             vec_q;
	job_t                job_q;
	logic                active;
	logic [1:0]          bit_cnt;
	logic                last_bit;
	logic [N_INPUTS-1:0] bits_hi_nib;
	logic [N_INPUTS-1:0] bits_lo_nib;
	logic [N_INPUTS-1:0] plane_hi_bits;
	logic [N_INPUTS-1:0] plane_lo_bits;
	logic [CNT_W-1:0]    cnt_hh;
	logic [CNT_W-1:0]    cnt_lh;
	logic [CNT_W-1:0]    cnt_hl;
	logic [CNT_W-1:0]    cnt_ll;
	logic [RESULT_W-1:0] slice_sum;
	logic [RESULT_W-1:0] acc;
	logic [RESULT_W-1:0] acc_next;

	// bit b of each nibble, and the two weight bit-planes
	for (genvar i = 0; i < N_INPUTS; i++) begin : g_split
		assign bits_hi_nib[i]   = vec_q[i*ELEM_W + NIB_W + bit_cnt];
		assign bits_lo_nib[i]   = vec_q[i*ELEM_W + bit_cnt];
		assign plane_hi_bits[i] = weight_data[2*i+1];
		assign plane_lo_bits[i] = weight_data[2*i];
	end

	crossbar_array #(.N_INPUTS(N_INPUTS), .N_COLS(N_COLS)) plane_hi_inst (
		.clk(clk), .reset(reset),
		.weight_wr(weight_wr), .weight_col(weight_col), .plane_bits(plane_hi_bits),
		.col(job_q.col_addr), .bits_hi_nib(bits_hi_nib), .bits_lo_nib(bits_lo_nib),
		.count_hi(cnt_hh), .count_lo(cnt_lh)
	);

	crossbar_array #(.N_INPUTS(N_INPUTS), .N_COLS(N_COLS)) plane_lo_inst (
		.clk(clk), .reset(reset),
		.weight_wr(weight_wr), .weight_col(weight_col), .plane_bits(plane_lo_bits),
		.col(job_q.col_addr), .bits_hi_nib(bits_hi_nib), .bits_lo_nib(bits_lo_nib),
		.count_hi(cnt_hl), .count_lo(cnt_ll)
	);

	// 16*(2*HH + HL) + (2*LH + LL), then weighted by 2^b
	assign slice_sum = ((RESULT_W'({cnt_hh, 1'b0}) + RESULT_W'(cnt_hl)) << NIB_W)
	                 + RESULT_W'({cnt_lh, 1'b0}) + RESULT_W'(cnt_ll);
	assign acc_next  = acc + (slice_sum << bit_cnt);
	assign last_bit  = (bit_cnt == LAST_BIT);

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			bit_cnt   <= '0;
			mac_valid <= 1'b0;
		end else begin
			mac_valid <= active && last_bit;
			if (job_load) begin
				active  <= 1'b1;   // a load on the last bit starts back to back
				bit_cnt <= '0;
			end else if (active) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (last_bit) active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (job_load) begin
			vec_q <= vector;
			job_q <= job;
			acc   <= '0;
		end else if (active) begin
			acc <= acc_next;
		end
		if (active && last_bit) begin
			result.vec_addr <= job_q.vec_addr;
			result.col_addr <= job_q.col_addr;
			result.value    <= acc_next;
			result.last     <= job_q.last;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		job_load |-> !active || last_bit)
		else $error("bit_serial_mac: job_load in the middle of a job");

	// weights feed the popcounts directly
	assert property (@(posedge clk) disable iff (reset)
		weight_wr |-> !active && !job_load)
		else $error("bit_serial_mac: weight_wr while a job is running");

endmodule

`default_nettype wire

// ==== logic/crossbar_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module crossbar_array #(
	parameter int N_INPUTS = pim_pkg::N_INPUTS,
	parameter int N_COLS = pim_pkg::N_COLS,
	localparam int CNT_W = $clog2(N_INPUTS + 1)
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               weight_wr,
	input  pim_pkg::col_addr_t weight_col,
	input  logic [N_INPUTS-1:0] plane_bits,
	input  pim_pkg::col_addr_t col,
	input  logic [N_INPUTS-1:0] bits_hi_nib,
	input  logic [N_INPUTS-1:0] bits_lo_nib,
	output logic [CNT_W-1:0]    count_hi,
	output logic [CNT_W-1:0]    count_lo
);

	logic [N_INPUTS-1:0] cells [N_COLS];   // one bit per row per column
	logic [N_COLS-1:0]   col_valid;        // columns written since reset
	logic [N_INPUTS-1:0] col_bits;
	logic [N_INPUTS-1:0] hi_hits;
	logic [N_INPUTS-1:0] lo_hits;

	always_ff @(posedge clk) begin
		if (weight_wr) begin
			cells[weight_col] <= plane_bits;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			col_valid <= '0;
		end else if (weight_wr) begin
			col_valid[weight_col] <= 1'b1;
		end
	end

	// unprogrammed columns read as zero weight
	assign col_bits = col_valid[col] ? cells[col] : '0;

	assign hi_hits = bits_hi_nib & col_bits;   // row currents into the column
	assign lo_hits = bits_lo_nib & col_bits;

	// exact popcount, no ADC clipping
	always_comb begin
		count_hi = '0;
		count_lo = '0;
		for (int i = 0; i < N_INPUTS; i++) begin
			count_hi = count_hi + CNT_W'(hi_hits[i]);
			count_lo = count_lo + CNT_W'(lo_hits[i]);
		end
	end

endmodule

`default_nettype wire

// ==== logic/job_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module job_sequencer #(
	parameter int N_COLS = pim_pkg::N_COLS,
	parameter int VEC_DEPTH = pim_pkg::VEC_DEPTH
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  pim_pkg::vec_addr_t start_vec,
	input  pim_pkg::vec_addr_t end_vec,
	input  pim_pkg::col_addr_t start_col,
	input  pim_pkg::col_addr_t end_col,
	output logic               busy,
	output logic               job_issue,
	output pim_pkg::job_t      job
);
	import pim_pkg::*;

	// issue at T, wait T+1..T+3, next issue at T+4
	localparam logic [2:0] ISSUE_GAP = 3'd2;
	// last issue at T, done at T+7, busy low at T+8
	localparam logic [2:0] DRAIN_GAP = 3'd6;

	seq_state_t state;
	logic [2:0] gap_cnt;
	logic       issued_last;   // the job just issued closes the run
	col_addr_t  start_col_q;
	col_addr_t  end_col_q;
	vec_addr_t  end_vec_q;
	col_addr_t  next_col;
	vec_addr_t  next_vec;
	logic       row_end;

	// column is the inner loop
	assign row_end  = (job.col_addr == end_col_q);
	assign next_col = row_end ? start_col_q : job.col_addr + 1'b1;
	assign next_vec = row_end ? job.vec_addr + 1'b1 : job.vec_addr;

	assign busy      = (state != seq_idle);
	assign job_issue = (state == seq_issue);

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= seq_idle;
			gap_cnt     <= '0;
			issued_last <= 1'b0;
		end else begin
			case (state)
				seq_idle: begin
					if (start) state <= seq_issue;   // start while busy never lands here
				end
				seq_issue: begin
					state       <= seq_wait;
					gap_cnt     <= '0;
					issued_last <= job.last;
				end
				seq_wait: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (!issued_last && gap_cnt == ISSUE_GAP) begin
						state <= seq_issue;
					end else if (issued_last && gap_cnt == DRAIN_GAP) begin
						state <= seq_idle;   // results drained, busy drops
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	// ranges and the current job
	always_ff @(posedge clk) begin
		if (state == seq_idle && start) begin
			start_col_q  <= start_col;
			end_col_q    <= end_col;
			end_vec_q    <= end_vec;
			job.vec_addr <= start_vec;
			job.col_addr <= start_col;
			job.last     <= (start_vec == end_vec) && (start_col == end_col);
		end else if (state == seq_issue && !job.last) begin
			job.vec_addr <= next_vec;
			job.col_addr <= next_col;
			job.last     <= (next_vec == end_vec_q) && (next_col == end_col_q);
		end
	end

	// an accepted run must be a legal, non-empty window of the array
	assert property (@(posedge clk) disable iff (reset)
		(start && state == seq_idle) |->
			(start_vec <= end_vec) && (start_col <= end_col) &&
			(int'(end_col) < N_COLS) && (int'(end_vec) < VEC_DEPTH))
		else $error("job_sequencer: bad address range on start");

endmodule

`default_nettype wire

// ==== logic/pim_pkg.sv ====
`default_nettype none

package pim_pkg;

	// array geometry, overridable per instance from the top level
	localparam int N_INPUTS = 8;     // elements per vector
	localparam int ELEM_W = 8;       // split into two nibbles
	localparam int N_COLS = 8;       // crossbar columns
	localparam int VEC_DEPTH = 4;    // vector buffer entries
	localparam int RESULT_W = 16;    // holds 8 x 255 x 3 exactly

	localparam int COL_AW = (N_COLS > 1) ? $clog2(N_COLS) : 1;
	localparam int VEC_AW = (VEC_DEPTH > 1) ? $clog2(VEC_DEPTH) : 1;

	typedef logic [COL_AW-1:0] col_addr_t;
	typedef logic [VEC_AW-1:0] vec_addr_t;

	// element i sits at bits [i*ELEM_W +: ELEM_W]
	typedef logic [N_INPUTS*ELEM_W-1:0] vector_t;

	typedef struct packed {
		vec_addr_t vec_addr;
		col_addr_t col_addr;
		logic      last;      // final job of a run
	} job_t;

	typedef struct packed {
		vec_addr_t           vec_addr;
		col_addr_t           col_addr;
		logic [RESULT_W-1:0] value;
		logic                last;
	} result_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_issue,   // job_issue high in this state
		seq_wait     // spacing between issues, or draining after the last one
	} seq_state_t;

endpackage

`default_nettype wire

// ==== logic/pim_vmm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pim_vmm_top #(
	parameter int N_INPUTS = pim_pkg::N_INPUTS,
	parameter int N_COLS = pim_pkg::N_COLS,
	parameter int VEC_DEPTH = pim_pkg::VEC_DEPTH
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  vec_wr,        // host vector write
	input  pim_pkg::vec_addr_t    vec_wr_addr,
	input  pim_pkg::vector_t      vec_wr_data,
	input  logic                  weight_wr,     // host column write, 2 bits per row
	input  pim_pkg::col_addr_t    weight_col,
	input  logic [2*N_INPUTS-1:0] weight_data,
	input  logic                  start,
	input  pim_pkg::vec_addr_t    start_vec,
	input  pim_pkg::vec_addr_t    end_vec,
	input  pim_pkg::col_addr_t    start_col,
	input  pim_pkg::col_addr_t    end_col,
	output logic                  result_valid,
	output pim_pkg::result_t      result,
	output logic                  done,
	output logic                  busy
);
	import pim_pkg::*;

	logic    job_issue;
	job_t    issue_job;
	logic    job_load;
	job_t    load_job;
	vector_t load_vector;
	logic    mac_valid;
	result_t mac_result;

	job_sequencer #(.N_COLS(N_COLS), .VEC_DEPTH(VEC_DEPTH)) seq_inst (
		.clk(clk), .reset(reset), .start(start),
		.start_vec(start_vec), .end_vec(end_vec), .start_col(start_col), .end_col(end_col),
		.busy(busy), .job_issue(job_issue), .job(issue_job)
	);

	vector_buffer #(.VEC_DEPTH(VEC_DEPTH)) vbuf_inst (
		.clk(clk), .reset(reset),
		.vec_wr(vec_wr), .vec_wr_addr(vec_wr_addr), .vec_wr_data(vec_wr_data),
		.job_issue(job_issue), .job_in(issue_job),
		.job_load(job_load), .job_out(load_job), .vector(load_vector)
	);

	bit_serial_mac #(.N_INPUTS(N_INPUTS), .N_COLS(N_COLS)) mac_inst (
		.clk(clk), .reset(reset),
		.job_load(job_load), .job(load_job), .vector(load_vector),
		.weight_wr(weight_wr), .weight_col(weight_col), .weight_data(weight_data),
		.mac_valid(mac_valid), .result(mac_result)
	);

	result_collector coll_inst (
		.clk(clk), .reset(reset),
		.mac_valid(mac_valid), .mac_result(mac_result),
		.result_valid(result_valid), .result(result), .done(done)
	);

endmodule

`default_nettype wire

// ==== logic/result_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_collector (
	input  logic             clk,
	input  logic             reset,
	input  logic             mac_valid,
	input  pim_pkg::result_t mac_result,
	output logic             result_valid,
	output pim_pkg::result_t result,
	output logic             done
);

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			done         <= 1'b0;
		end else begin
			result_valid <= mac_valid;
			done         <= mac_valid && mac_result.last;   // same cycle as the last result
		end
	end

	// payload only moves with a valid result
	always_ff @(posedge clk) begin
		if (mac_valid) begin
			result <= mac_result;
		end
	end

	// the MAC needs four bit cycles per job, so results never come closer
	assert property (@(posedge clk) disable iff (reset)
		mac_valid |=> !mac_valid [*3])
		else $error("result_collector: results closer than four cycles");

endmodule

`default_nettype wire

// ==== logic/vector_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_buffer #(
	parameter int VEC_DEPTH = pim_pkg::VEC_DEPTH
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               vec_wr,
	input  pim_pkg::vec_addr_t vec_wr_addr,
	input  pim_pkg::vector_t   vec_wr_data,
	input  logic               job_issue,
	input  pim_pkg::job_t      job_in,
	output logic               job_load,
	output pim_pkg::job_t      job_out,
	output pim_pkg::vector_t   vector
);
	import pim_pkg::*;

	vector_t   mem [VEC_DEPTH];
	vec_addr_t mem_addr;

	// one shared port, host writes take it
	assign mem_addr = vec_wr ? vec_wr_addr : job_in.vec_addr;

	always_ff @(posedge clk) begin
		if (vec_wr) begin
			mem[mem_addr] <= vec_wr_data;
		end else if (job_issue) begin
			vector  <= mem[mem_addr];
			job_out <= job_in;   // tag follows the read data
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			job_load <= 1'b0;
		end else begin
			job_load <= job_issue;   // data valid one cycle after issue
		end
	end

	// host writes only happen outside of a run, so they never steal the port
	assert property (@(posedge clk) disable iff (reset)
		vec_wr |-> !job_issue && !job_load)
		else $error("vector_buffer: vec_wr while a job is being fetched");

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+tests
logic/pim_pkg.sv
logic/vector_buffer.sv
logic/job_sequencer.sv
logic/crossbar_array.sv
logic/bit_serial_mac.sv
logic/result_collector.sv
logic/pim_vmm_top.sv
tests/pim_vmm_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module pim_vmm_tb \
	-f project.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi
./obj_dir/Vpim_vmm_tb > sim.log 2>&1
status=$?
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

// ==== tests/vmm_model.svh ====
`ifndef VMM_MODEL_SVH
`define VMM_MODEL_SVH

// host-side copies of everything written into the DUT
vector_t               model_vec [VEC_DEPTH];
logic [2*N_INPUTS-1:0] model_w [N_COLS];
result_t               exp_q [$];   // outstanding jobs, in issue order

// unsigned dot product of one vector with one column of 2-bit weights
function automatic int unsigned expected_dot(input int v, input int c);
	int unsigned sum;
	int unsigned elem;
	int unsigned wt;
	sum = 0;
	for (int i = 0; i < N_INPUTS; i++) begin
		elem = model_vec[v][i*ELEM_W +: ELEM_W];
		wt   = model_w[c][2*i +: 2];
		sum  = sum + elem * wt;
	end
	return sum;
endfunction

// vector outer, column inner, both inclusive
function automatic int queue_run(input int sv, input int ev, input int sc, input int ec);
	result_t r;
	int n;
	n = 0;
	for (int v = sv; v <= ev; v++) begin
		for (int c = sc; c <= ec; c++) begin
			r.vec_addr = vec_addr_t'(v);
			r.col_addr = col_addr_t'(c);
			r.value    = RESULT_W'(expected_dot(v, c));
			r.last     = (v == ev) && (c == ec);
			exp_q.push_back(r);
			n++;
		end
	end
	return n;
endfunction

`endif

// ==== tests/pim_vmm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pim_vmm_tb;
	import pim_pkg::*;

	localparam int MAX_JOBS = VEC_DEPTH * N_COLS;
	localparam int N_RUNS = 10;
	localparam int TIMEOUT_CYCLES = N_RUNS * (MAX_JOBS * 4 + 20) + 1000;

	logic                  clk;
	logic                  reset;
	logic                  vec_wr;
	vec_addr_t             vec_wr_addr;
	vector_t               vec_wr_data;
	logic                  weight_wr;
	col_addr_t             weight_col;
	logic [2*N_INPUTS-1:0] weight_data;
	logic                  start;
	vec_addr_t             start_vec;
	vec_addr_t             end_vec;
	col_addr_t             start_col;
	col_addr_t             end_col;
	logic                  result_valid;
	result_t               result;
	logic                  done;
	logic                  busy;

	integer              seed = 32'hf9f5bcc4;
	int unsigned         cyc = 0;
	int unsigned         start_cycle = 0;
	int unsigned         last_cycle = 0;
	logic                first_pending = 1'b0;   // waiting for the first result of a run
	int                  run_results = 0;
	logic [RESULT_W-1:0] last_value;

	`include "vmm_model.svh"

	pim_vmm_top #(.N_INPUTS(N_INPUTS), .N_COLS(N_COLS), .VEC_DEPTH(VEC_DEPTH)) pim_vmm_top_inst (
		.clk(clk), .reset(reset),
		.vec_wr(vec_wr), .vec_wr_addr(vec_wr_addr), .vec_wr_data(vec_wr_data),
		.weight_wr(weight_wr), .weight_col(weight_col), .weight_data(weight_data),
		.start(start), .start_vec(start_vec), .end_vec(end_vec),
		.start_col(start_col), .end_col(end_col),
		.result_valid(result_valid), .result(result), .done(done), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want));
		end
	endtask

	// outputs read at the edge before the DUT updates them
	always @(posedge clk) begin
		result_t want;
		if (!reset) begin
			if (start && !busy) begin   // accepted start
				start_cycle   = cyc;
				first_pending = 1'b1;
			end
			if (first_pending && cyc == start_cycle + 1) check("busy", busy, 1'b1);
			if (done && !result_valid) abort_run("done pulsed without a result");
			if (result_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("result_valid with no job outstanding");
				end else begin
					want = exp_q.pop_front();
					check("result.vec_addr", result.vec_addr, want.vec_addr);
					check("result.col_addr", result.col_addr, want.col_addr);
					check("result.value", result.value, want.value);
					check("result.last", result.last, want.last);
					check("done", done, want.last);
					if (first_pending) check("first result latency", cyc - start_cycle, 8);
					else check("result spacing", cyc - last_cycle, 4);
					first_pending = 1'b0;
					last_cycle    = cyc;
					last_value    = result.value;
					run_results++;
				end
			end
		end
		cyc++;
	end

	task automatic write_vector(input int addr, input vector_t data);
		@(posedge clk);
		vec_wr      <= 1'b1;
		vec_wr_addr <= vec_addr_t'(addr);
		vec_wr_data <= data;
		@(posedge clk);
		vec_wr <= 1'b0;
		model_vec[addr] = data;
	endtask

	task automatic write_weights(input int col, input logic [2*N_INPUTS-1:0] data);
		@(posedge clk);
		weight_wr   <= 1'b1;
		weight_col  <= col_addr_t'(col);
		weight_data <= data;
		@(posedge clk);
		weight_wr <= 1'b0;
		model_w[col] = data;
	endtask

	// random == 1 ignores elem and wt
	task automatic load_data(input bit random, input logic [7:0] elem, input logic [1:0] wt);
		vector_t v;
		logic [2*N_INPUTS-1:0] w;
		for (int a = 0; a < VEC_DEPTH; a++) begin
			for (int i = 0; i < N_INPUTS; i++) begin
				v[i*ELEM_W +: ELEM_W] = random ? ELEM_W'($random(seed)) : elem;
			end
			write_vector(a, v);
		end
		for (int c = 0; c < N_COLS; c++) begin
			for (int i = 0; i < N_INPUTS; i++) w[2*i +: 2] = random ? 2'($random(seed)) : wt;
			write_weights(c, w);
		end
	endtask

	task automatic run_range(input int sv, input int ev, input int sc, input int ec, input bit poke);
		int n;
		n = queue_run(sv, ev, sc, ec);
		run_results = 0;
		@(posedge clk);
		start     <= 1'b1;
		start_vec <= vec_addr_t'(sv);
		end_vec   <= vec_addr_t'(ev);
		start_col <= col_addr_t'(sc);
		end_col   <= col_addr_t'(ec);
		@(posedge clk);
		start <= 1'b0;
		if (poke) begin   // second start mid-run must be dropped
			repeat (5) @(posedge clk);
			start     <= 1'b1;
			start_vec <= '0;
			end_vec   <= vec_addr_t'(VEC_DEPTH - 1);
			@(posedge clk);
			start <= 1'b0;
		end
		while (!done) @(posedge clk);
		@(posedge clk);
		while (busy) @(posedge clk);
		check("result count", run_results, n);
		check("jobs left in model", exp_q.size(), 0);
	endtask

	task automatic random_range_run(input bit single);
		int unsigned v0;
		int unsigned v1;
		int unsigned c0;
		int unsigned c1;
		v0 = $unsigned($random(seed)) % VEC_DEPTH;
		c0 = $unsigned($random(seed)) % N_COLS;
		v1 = single ? v0 : $unsigned($random(seed)) % VEC_DEPTH;
		c1 = single ? c0 : $unsigned($random(seed)) % N_COLS;
		run_range((v0 < v1) ? v0 : v1, (v0 < v1) ? v1 : v0,
			(c0 < c1) ? c0 : c1, (c0 < c1) ? c1 : c0, 1'b0);
	endtask

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		abort_run($sformatf("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin
		reset       <= 1'b1;
		vec_wr      <= 1'b0;
		vec_wr_addr <= '0;
		vec_wr_data <= '0;
		weight_wr   <= 1'b0;
		weight_col  <= '0;
		weight_data <= '0;
		start       <= 1'b0;
		start_vec   <= '0;
		end_vec     <= '0;
		start_col   <= '0;
		end_col     <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		repeat (10) begin   // idle with nothing moving
			@(posedge clk);
			check("result_valid", result_valid, 1'b0);
			check("done", done, 1'b0);
			check("busy", busy, 1'b0);
		end
		load_data(1'b1, 8'h00, 2'd0);
		run_range(0, VEC_DEPTH - 1, 0, N_COLS - 1, 1'b0);
		random_range_run(1'b1);
		repeat (5) random_range_run(1'b0);
		load_data(1'b0, 8'hff, 2'd3);   // full scale
		run_range(0, VEC_DEPTH - 1, 0, N_COLS - 1, 1'b0);
		check("full-scale value", last_value, N_INPUTS * 765);
		load_data(1'b0, 8'h00, 2'd0);
		run_range(0, VEC_DEPTH - 1, 0, N_COLS - 1, 1'b0);
		check("zero value", last_value, 0);
		load_data(1'b1, 8'h00, 2'd0);
		run_range(0, VEC_DEPTH - 1, 0, N_COLS - 1, 1'b1);
		repeat (16) begin   // a dropped start leaves no second run behind
			@(posedge clk);
			check("busy", busy, 1'b0);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
